// File: Makefile
TOP = rob_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f rob_top.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: rob_top.f
+incdir+verilog
verilog/rob_pkg.sv
verilog/rob_store.sv
verilog/rob_ctrl.sv
verilog/rob_branch.sv
verilog/rob_top.sv
tests/rob_tb.sv

// File: tests/rob_tb.sv
// testbench for the reorder buffer
// reference queue model, LFSR stimulus, concurrent assertions and a cycle limit
`timescale 1ns/100ps
`default_nettype none

`include "rob_config.svh"

module rob_tb;

	import rob_pkg::*;

	localparam int MAX_CYCLES = 4000;

	typedef struct packed {
		rob_idx_t      idx;
		logic          done;
		rob_dispatch_t info;
	} ref_entry_t;

	logic          clk;
	logic          rst;
	logic          dispatch_valid;
	rob_dispatch_t dispatch;
	logic          complete_valid;
	rob_complete_t complete;
	rob_idx_t      npc_rd_idx;
	rob_idx_t      tail_idx;
	logic          stall;
	logic          retire_valid;
	rob_retire_t   retire;
	logic          br_right;
	logic          recover_valid;
	rob_recover_t  recover;
	addr_t         npc;

	// ------------------------------
	// reference model state
	// ------------------------------
	ref_entry_t   ref_q[$];         // live entries with the oldest first
	rob_idx_t     exp_tail;
	logic         exp_stall;
	logic         exp_retire_valid;
	rob_retire_t  exp_retire;
	logic         exp_br_right;
	logic         exp_mispredict;
	rob_recover_t exp_recover;
	addr_t        exp_npc;
	logic         npc_check;
	logic         accept;           // dispatch taken at the coming edge
	int           cmp_pos;          // queue position of the completing entry
	logic [15:0]  lfsr_state;
	int           cycle_count = 0;
	string        test_name;

	rob_top dut_i (
		.clk              (clk),
		.rst              (rst),
		.dispatch_valid_i (dispatch_valid),
		.dispatch_i       (dispatch),
		.tail_idx_o       (tail_idx),
		.stall_o          (stall),
		.complete_valid_i (complete_valid),
		.complete_i       (complete),
		.npc_rd_idx_i     (npc_rd_idx),
		.npc_o            (npc),
		.retire_valid_o   (retire_valid),
		.retire_o         (retire),
		.br_right_o       (br_right),
		.recover_valid_o  (recover_valid),
		.recover_o        (recover)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic report_mismatch(input string what, input logic [63:0] exp_val,
			input logic [63:0] act_val);
		$display("ERR %s %s expected %h actual %h", test_name, what, exp_val, act_val);
		$display("Test failed");
		$fatal(1, "check failed");
	endtask

	// ------------------------------
	// checks
	// ------------------------------
	a_tail: assert property (@(posedge clk) disable iff (rst) tail_idx == exp_tail)
		else report_mismatch("tail_idx", 64'(exp_tail), 64'(tail_idx));
	a_stall: assert property (@(posedge clk) disable iff (rst) stall == exp_stall)
		else report_mismatch("stall", 64'(exp_stall), 64'(stall));
	a_retire_valid: assert property (@(posedge clk) disable iff (rst)
		retire_valid == exp_retire_valid)
		else report_mismatch("retire_valid", 64'(exp_retire_valid), 64'(retire_valid));
	a_retire: assert property (@(posedge clk) disable iff (rst) retire == exp_retire)
		else report_mismatch("retire", 64'(exp_retire), 64'(retire));
	a_branch: assert property (@(posedge clk) disable iff (rst)
		{br_right, recover_valid} == {exp_br_right, exp_mispredict})
		else report_mismatch("br_right/recover_valid", 64'({exp_br_right, exp_mispredict}),
			64'({br_right, recover_valid}));
	a_recover: assert property (@(posedge clk) disable iff (rst) recover == exp_recover)
		else report_mismatch("recover", 64'(exp_recover), 64'(recover));
	a_npc: assert property (@(posedge clk) disable iff (rst) npc_check |-> npc == exp_npc)
		else report_mismatch("npc", exp_npc, npc);

	// galois LFSR stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		end
		return r;
	endfunction

	// expected outputs for the inputs driven in this cycle
	function automatic void compute_expected();
		rob_branch_info_t bi;
		exp_retire_valid = 1'b0;
		exp_retire = '0;
		if (ref_q.size() > 0) begin
			exp_retire_valid = ref_q[0].done;
		end
		if (exp_retire_valid) begin
			exp_retire.old_tag   = ref_q[0].info.retire_info.old_tag;
			exp_retire.new_tag   = ref_q[0].info.retire_info.new_tag;
			exp_retire.arch_dest = ref_q[0].info.retire_info.arch_dest;
		end
		exp_stall = (ref_q.size() == `ROB_DEPTH) && !exp_retire_valid;
		exp_br_right = 1'b0;
		exp_mispredict = 1'b0;
		exp_recover = '0;
		cmp_pos = -1;
		if (complete_valid) begin
			for (int i = 0; i < ref_q.size(); i++)
				if (ref_q[i].idx == complete.idx)
					cmp_pos = i;
		end
		if (cmp_pos >= 0) begin
			bi = ref_q[cmp_pos].info.branch_info;
			if (bi.br_flag) begin
				exp_br_right = (complete.taken == bi.pred_taken) &&
					(complete.target == bi.pred_target);
				exp_mispredict = !exp_br_right;
				exp_recover.br_mask = bi.br_mask;
				exp_recover.fl_head = bi.fl_head;
			end
		end
		accept = dispatch_valid && !exp_stall && !exp_mispredict;
	endfunction

	// apply what happened at the last edge
	task automatic update_model();
		ref_entry_t e;
		if (cmp_pos >= 0)
			ref_q[cmp_pos].done = 1'b1;
		if (exp_mispredict) begin
			while (ref_q.size() > cmp_pos + 1)
				ref_q.delete(ref_q.size() - 1);  // squash younger entries
			exp_tail = ref_q[cmp_pos].idx + rob_idx_t'(1);
		end
		if (accept) begin
			e.idx = exp_tail;
			e.done = 1'b0;
			e.info = dispatch;
			ref_q.push_back(e);
			exp_tail = exp_tail + rob_idx_t'(1);
		end
		if (exp_retire_valid)
			ref_q.delete(0);
	endtask

	task automatic pick_npc_read();
		int p;
		npc_check = 1'b0;
		if (ref_q.size() > 0) begin
			p = int'(take_bits(5)) % ref_q.size();
			npc_rd_idx = ref_q[p].idx;
			exp_npc = ref_q[p].info.branch_info.pc + addr_t'(`INSN_BYTES);
			npc_check = 1'b1;
		end
	endtask

	task automatic cycle();
		pick_npc_read();
		compute_expected();
		@(posedge clk);
		#2;
		update_model();
		dispatch_valid = 1'b0;
		complete_valid = 1'b0;
		compute_expected();
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------
	task automatic dispatch_entry(input logic is_branch);
		rob_dispatch_t d;
		d = '0;
		d.retire_info.old_tag     = prf_tag_t'(take_bits(`PRF_TAG_W));
		d.retire_info.new_tag     = prf_tag_t'(take_bits(`PRF_TAG_W));
		d.retire_info.arch_dest   = arch_reg_t'(take_bits(`ARCH_REG_W));
		d.branch_info.pc          = addr_t'({take_bits(30), 2'b00});
		d.branch_info.br_flag     = is_branch;
		d.branch_info.pred_taken  = take_bits(1) != 0;
		d.branch_info.pred_target = addr_t'({take_bits(30), 2'b00});
		d.branch_info.br_mask     = br_mask_t'(take_bits(`BR_MASK_W));
		d.branch_info.fl_head     = fl_ptr_t'(take_bits(`FL_PTR_W));
		dispatch_valid = 1'b1;
		dispatch = d;
		cycle();
	endtask

	task automatic complete_entry(input int pos, input logic taken, input addr_t target);
		complete_valid = 1'b1;
		complete.idx = ref_q[pos].idx;
		complete.taken = taken;
		complete.target = target;
		cycle();
	endtask

	task automatic complete_as_predicted(input int pos);
		rob_branch_info_t bi;
		bi = ref_q[pos].info.branch_info;
		complete_entry(pos, bi.pred_taken, bi.pred_target);
	endtask

	task automatic complete_random();
		int pend[$];
		int k;
		for (int i = 0; i < ref_q.size(); i++)
			if (!ref_q[i].done)
				pend.push_back(i);
		if (pend.size() == 0) begin
			cycle();  // only retirements left
		end else begin
			k = int'(take_bits(5)) % pend.size();
			complete_as_predicted(pend[k]);
		end
	endtask

	task automatic drain();
		while (ref_q.size() > 0)
			complete_random();
	endtask

	initial begin
		rob_branch_info_t bi;
		rst = 1'b1;
		dispatch_valid = 1'b0;
		dispatch = '0;
		complete_valid = 1'b0;
		complete = '0;
		npc_rd_idx = '0;
		exp_tail = '0;
		npc_check = 1'b0;
		lfsr_state = 16'd64;
		test_name = "reset";
		compute_expected();
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		repeat (3) cycle();

		test_name = "in_order";
		repeat (20) dispatch_entry(1'b0);
		drain();

		test_name = "full";
		repeat (`ROB_DEPTH) dispatch_entry(1'b0);
		dispatch_entry(1'b0);       // rejected so the tail holds
		complete_as_predicted(0);
		dispatch_entry(1'b0);       // accepted while the head retires
		drain();

		test_name = "branch_right";
		repeat (3) dispatch_entry(1'b0);
		dispatch_entry(1'b1);
		repeat (2) dispatch_entry(1'b0);
		complete_as_predicted(3);
		drain();

		test_name = "branch_wrong";
		repeat (2) dispatch_entry(1'b0);
		dispatch_entry(1'b1);
		repeat (3) dispatch_entry(1'b0);
		complete_as_predicted(4);   // younger entry finishes before the branch
		bi = ref_q[2].info.branch_info;
		complete_entry(2, ~bi.pred_taken, bi.pred_target);
		repeat (2) dispatch_entry(1'b0);
		drain();

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/rob_branch.sv
// branch resolution for the reorder buffer
// checks a completing branch against its stored prediction
// and forms the next pc for the branch unit read port
`timescale 1ns/100ps
`default_nettype none

`include "rob_config.svh"

module rob_branch (
	// completion from a functional unit
	input  wire logic                       complete_valid_i,
	input  wire rob_pkg::rob_complete_t     complete_i,

	// stored branch fields of the completing entry
	input  wire rob_pkg::rob_branch_info_t  br_info_i,

	// stored fields of the entry picked by the next pc read
	input  wire rob_pkg::rob_branch_info_t  npc_info_i,

	output      logic                       br_right_o,
	output      logic                       recover_valid_o,
	output      rob_pkg::rob_recover_t      recover_o,
	output      rob_pkg::addr_t             npc_o
);

	import rob_pkg::*;

	// ------------------------------
	// resolution
	// ------------------------------
	logic br_hit;       // completion names a branch entry
	logic taken_miss;
	logic target_miss;
	logic mispredict;

	assign br_hit      = complete_valid_i & br_info_i.br_flag;
	assign taken_miss  = (complete_i.taken != br_info_i.pred_taken);
	assign target_miss = (complete_i.target != br_info_i.pred_target);
	assign mispredict  = taken_miss | target_miss;

	assign recover_valid_o = br_hit & mispredict;   // early recovery
	assign br_right_o      = br_hit & ~mispredict;

	// mask and free list head go out for both outcomes
	always_comb begin
		recover_o = '0;
		if (br_hit) begin
			recover_o.br_mask = br_info_i.br_mask;
			recover_o.fl_head = br_info_i.fl_head;
		end
	end

	// ------------------------------
	// next pc read
	// ------------------------------
	assign npc_o = npc_info_i.pc + addr_t'(`INSN_BYTES);  // fall through address

endmodule

`default_nettype wire

// File: verilog/rob_config.svh
// reorder buffer configuration
// sizes of the entry array, tags, masks and addresses
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// ------------------------------
// buffer geometry
// ------------------------------
`define ROB_DEPTH   32  // entry count as a power of two
`define ROB_IDX_W   5   // log2 of ROB_DEPTH

// ------------------------------
// rename and branch state
// ------------------------------
`define PRF_TAG_W   6   // physical register tag
`define ARCH_REG_W  5   // logical register number
`define FL_PTR_W    5   // free list head pointer
`define BR_MASK_W   4   // one bit per outstanding branch

`define ADDR_W      64
`define INSN_BYTES  4   // fixed instruction size

`endif

// File: verilog/rob_ctrl.sv
// reorder buffer control
// head and tail pointers with wrap bits, per entry done bits,
// full and stall, retirement gating and tail rollback on recovery
`timescale 1ns/100ps
`default_nettype none

`include "rob_config.svh"

module rob_ctrl (
	input  wire logic                       clk,
	input  wire logic                       rst,

	// dispatch and completion
	input  wire logic                       dispatch_valid_i,
	input  wire logic                       complete_valid_i,
	input  wire rob_pkg::rob_idx_t          complete_idx_i,
	input  wire logic                       recover_i,      // mispredict seen this cycle

	// head entry fields from the retire bank
	input  wire rob_pkg::rob_retire_info_t  retire_info_i,

	// store control
	output      logic                       wr_en_o,
	output      rob_pkg::rob_idx_t          wr_idx_o,
	output      rob_pkg::rob_idx_t          head_idx_o,

	output      rob_pkg::rob_idx_t          tail_idx_o,
	output      logic                       stall_o,
	output      logic                       retire_valid_o,
	output      rob_pkg::rob_retire_t       retire_o
);

	import rob_pkg::*;

	// ------------------------------
	// state
	// ------------------------------
	rob_ptr_t              head_r;
	rob_ptr_t              tail_r;
	logic [`ROB_DEPTH-1:0] done_r;

	rob_ptr_t head_nxt;
	rob_ptr_t tail_nxt;
	rob_ptr_t count;        // live entries from 0 to ROB_DEPTH
	rob_idx_t head_idx;
	rob_idx_t tail_idx;
	rob_idx_t br_dist;      // head to branch distance
	logic     full;
	logic     empty;
	logic     alloc;

	assign head_idx = head_r[`ROB_IDX_W-1:0];
	assign tail_idx = tail_r[`ROB_IDX_W-1:0];
	assign count    = tail_r - head_r;
	assign full     = (count == rob_ptr_t'(`ROB_DEPTH));
	assign empty    = (count == '0);

	// ------------------------------
	// retire and dispatch
	// ------------------------------
	// stale done bits of squashed entries can sit at an empty head
	assign retire_valid_o = ~empty & done_r[head_idx];

	// a full buffer that retires this cycle frees the slot it needs
	assign stall_o = full & ~retire_valid_o;
	assign alloc   = dispatch_valid_i & ~stall_o & ~recover_i;

	assign wr_en_o    = alloc;
	assign wr_idx_o   = tail_idx;
	assign head_idx_o = head_idx;
	assign tail_idx_o = tail_idx;

	always_comb begin
		retire_o = '0;
		if (retire_valid_o) begin
			retire_o.old_tag   = retire_info_i.old_tag;
			retire_o.new_tag   = retire_info_i.new_tag;
			retire_o.arch_dest = retire_info_i.arch_dest;
		end
	end

	// ------------------------------
	// pointer update
	// ------------------------------
	assign br_dist = complete_idx_i - head_idx;  // wraps modulo depth

	always_comb begin
		head_nxt = head_r + rob_ptr_t'(retire_valid_o);

		if (recover_i) begin
			// keep head through branch so the wrap bit follows from the distance
			tail_nxt = head_r + {1'b0, br_dist} + rob_ptr_t'(1);
		end else if (alloc) begin
			tail_nxt = tail_r + rob_ptr_t'(1);
		end else begin
			tail_nxt = tail_r;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			head_r <= head_nxt;
			tail_r <= tail_nxt;
		end
	end

	// ------------------------------
	// done bits
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			done_r <= '0;
		end else begin
			if (alloc)
				done_r[tail_idx] <= 1'b0;         // fresh entry
			if (retire_valid_o)
				done_r[head_idx] <= 1'b0;
			if (complete_valid_i)
				done_r[complete_idx_i] <= 1'b1;   // set last so it wins over the clears
		end
	end

endmodule

`default_nettype wire

// File: verilog/rob_pkg.sv
// shared types of the reorder buffer
// index, pointer and tag types, and the packed structs used on the ports
`default_nettype none

`include "rob_config.svh"

package rob_pkg;

	// ------------------------------
	// scalar types
	// ------------------------------
	typedef logic [`ROB_IDX_W-1:0]  rob_idx_t;
	typedef logic [`ROB_IDX_W:0]    rob_ptr_t;   // msb is the wrap bit
	typedef logic [`PRF_TAG_W-1:0]  prf_tag_t;
	typedef logic [`ARCH_REG_W-1:0] arch_reg_t;
	typedef logic [`FL_PTR_W-1:0]   fl_ptr_t;
	typedef logic [`BR_MASK_W-1:0]  br_mask_t;
	typedef logic [`ADDR_W-1:0]     addr_t;

	// ------------------------------
	// per entry payloads
	// ------------------------------
	typedef struct packed {
		prf_tag_t  old_tag;     // goes back to the free list
		prf_tag_t  new_tag;     // goes to the architectural map
		arch_reg_t arch_dest;
	} rob_retire_info_t;

	typedef struct packed {
		addr_t    pc;
		logic     br_flag;      // entry is a branch
		logic     pred_taken;
		addr_t    pred_target;
		br_mask_t br_mask;
		fl_ptr_t  fl_head;      // free list head at dispatch
	} rob_branch_info_t;

	// ------------------------------
	// port bundles
	// ------------------------------
	typedef struct packed {
		rob_retire_info_t retire_info;
		rob_branch_info_t branch_info;
	} rob_dispatch_t;

	typedef struct packed {
		rob_idx_t idx;          // entry that finished
		logic     taken;        // resolved direction
		addr_t    target;       // resolved target
	} rob_complete_t;

	typedef struct packed {
		prf_tag_t  old_tag;
		prf_tag_t  new_tag;
		arch_reg_t arch_dest;
	} rob_retire_t;

	typedef struct packed {
		br_mask_t br_mask;
		fl_ptr_t  fl_head;
	} rob_recover_t;

endpackage

`default_nettype wire

// File: verilog/rob_store.sv
// entry array of the reorder buffer
// one synchronous write port, two combinational read ports
// payload type is a parameter so one module serves every field group
`timescale 1ns/100ps
`default_nettype none

`include "rob_config.svh"

module rob_store #(
	parameter type entry_t = logic [7:0],
	parameter int  DEPTH   = `ROB_DEPTH
) (
	input  wire logic              clk,
	input  wire logic              rst,

	// write side, driven by the control block
	input  wire logic              we_i,
	input  wire rob_pkg::rob_idx_t waddr_i,
	input  wire entry_t            wdata_i,

	// read side
	input  wire rob_pkg::rob_idx_t raddr_a_i,
	input  wire rob_pkg::rob_idx_t raddr_b_i,
	output      entry_t            rdata_a_o,
	output      entry_t            rdata_b_o
);

	// ------------------------------
	// storage
	// ------------------------------
	entry_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (rst) begin
			mem <= '{default: '0};
		end else if (we_i) begin
			mem[waddr_i] <= wdata_i;  // allocation at the tail
		end
	end

	// ------------------------------
	// read ports
	// ------------------------------
	// reads see the old contents during a write to the same entry

	always_comb begin
		rdata_a_o = mem[raddr_a_i];
	end

	always_comb begin
		rdata_b_o = mem[raddr_b_i];
	end

endmodule

`default_nettype wire

// File: verilog/rob_top.sv
// reorder buffer top level
// two storage banks, the control block and the branch block
`timescale 1ns/100ps
`default_nettype none

`include "rob_config.svh"

module rob_top (
	input  wire logic                    clk,
	input  wire logic                    rst,

	// dispatch
	input  wire logic                    dispatch_valid_i,
	input  wire rob_pkg::rob_dispatch_t  dispatch_i,
	output      rob_pkg::rob_idx_t       tail_idx_o,
	output      logic                    stall_o,

	// completion
	input  wire logic                    complete_valid_i,
	input  wire rob_pkg::rob_complete_t  complete_i,

	// next pc read for the branch unit
	input  wire rob_pkg::rob_idx_t       npc_rd_idx_i,
	output      rob_pkg::addr_t          npc_o,

	// retirement to free list and architectural map
	output      logic                    retire_valid_o,
	output      rob_pkg::rob_retire_t    retire_o,

	// branch outcome and early recovery
	output      logic                    br_right_o,
	output      logic                    recover_valid_o,
	output      rob_pkg::rob_recover_t   recover_o
);

	import rob_pkg::*;

	logic             wr_en;
	rob_idx_t         wr_idx;
	rob_idx_t         head_idx;
	rob_retire_info_t head_info;  // rename fields of the head entry
	rob_branch_info_t br_info;    // branch fields of the completing entry
	rob_branch_info_t npc_info;

	// ------------------------------
	// storage banks
	// ------------------------------
	rob_store #(
		.entry_t (rob_retire_info_t),
		.DEPTH   (`ROB_DEPTH)
	) retire_bank_i (
		.clk       (clk),
		.rst       (rst),
		.we_i      (wr_en),
		.waddr_i   (wr_idx),
		.wdata_i   (dispatch_i.retire_info),
		.raddr_a_i (head_idx),
		.raddr_b_i (head_idx),
		.rdata_a_o (head_info),
		.rdata_b_o ()              // only the head is read here
	);

	rob_store #(
		.entry_t (rob_branch_info_t),
		.DEPTH   (`ROB_DEPTH)
	) branch_bank_i (
		.clk       (clk),
		.rst       (rst),
		.we_i      (wr_en),
		.waddr_i   (wr_idx),
		.wdata_i   (dispatch_i.branch_info),
		.raddr_a_i (complete_i.idx),
		.raddr_b_i (npc_rd_idx_i),
		.rdata_a_o (br_info),
		.rdata_b_o (npc_info)
	);

	// ------------------------------
	// control and branch blocks
	// ------------------------------
	rob_ctrl ctrl_i (
		.clk              (clk),
		.rst              (rst),
		.dispatch_valid_i (dispatch_valid_i),
		.complete_valid_i (complete_valid_i),
		.complete_idx_i   (complete_i.idx),
		.recover_i        (recover_valid_o),
		.retire_info_i    (head_info),
		.wr_en_o          (wr_en),
		.wr_idx_o         (wr_idx),
		.head_idx_o       (head_idx),
		.tail_idx_o       (tail_idx_o),
		.stall_o          (stall_o),
		.retire_valid_o   (retire_valid_o),
		.retire_o         (retire_o)
	);

	rob_branch branch_i (
		.complete_valid_i (complete_valid_i),
		.complete_i       (complete_i),
		.br_info_i        (br_info),
		.npc_info_i       (npc_info),
		.br_right_o       (br_right_o),
		.recover_valid_o  (recover_valid_o),
		.recover_o        (recover_o),
		.npc_o            (npc_o)
	);

endmodule

`default_nettype wire
